// File: fb_display.f
rtl/disp_timing_pkg.sv
rtl/fb_mem_pkg.sv
rtl/fb_ram.sv
rtl/fb_arbiter.sv
rtl/fb_draw.sv
rtl/fb_scan.sv
rtl/fb_display_top.sv
tb/fb_display_tb.sv

// File: rtl/disp_timing_pkg.sv
package disp_timing_pkg;

    // ----------------------------------------------------------
    // horizontal timing in clocks
    // ----------------------------------------------------------
    localparam int H_DISP  = 32;                                   // active pixels per line
    localparam int H_FRONT = 2;                                    // front porch
    localparam int H_SYNC  = 3;                                    // hs pulse width
    localparam int H_BACK  = 3;                                    // back porch
    localparam int H_TOTAL = H_DISP + H_FRONT + H_SYNC + H_BACK;   // 40 clocks per line

    // ----------------------------------------------------------
    // vertical timing in lines
    // ----------------------------------------------------------
    localparam int V_DISP  = 16;                                   // active lines per frame
    localparam int V_FRONT = 1;                                    // front porch
    localparam int V_SYNC  = 2;                                    // vs pulse width
    localparam int V_BACK  = 1;                                    // back porch
    localparam int V_TOTAL = V_DISP + V_FRONT + V_SYNC + V_BACK;   // 20 lines per frame

    localparam int H_CW = $clog2(H_TOTAL);                         // line counter width
    localparam int V_CW = $clog2(V_TOTAL);                         // frame counter width
    localparam int X_W  = $clog2(H_DISP);                          // pixel column width
    localparam int Y_W  = $clog2(V_DISP);                          // pixel row width

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;                                                       // 24 bit pixel

    // parallel video port, syncs active high
    typedef struct packed {
        logic hs;
        logic vs;
        logic de;
        rgb_t rgb;
    } video_t;

endpackage

// File: rtl/fb_arbiter.sv
`timescale 1ns/100ps

module fb_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fb_mem_pkg::fb_req_t   scan_req,   // reader that always wins
    output fb_mem_pkg::fb_rsp_t   scan_rsp,
    input  fb_mem_pkg::fb_req_t   draw_req,   // writer that takes the gaps
    output fb_mem_pkg::fb_rsp_t   draw_rsp,
    output fb_mem_pkg::fb_req_t   mem_req,    // into the frame memory
    input  disp_timing_pkg::rgb_t mem_rdata   // from the frame memory
);

    logic scan_win;                           // scan owns the port this cycle
    logic draw_win;                           // draw owns the port this cycle
    logic rd_from_scan;                       // owner of the last granted read

    // ----------------------------------------------------------
    // fixed priority select
    // ----------------------------------------------------------
    assign scan_win = scan_req.req;
    assign draw_win = draw_req.req & ~scan_req.req;

    // idle draw request passes through with req low
    assign mem_req = scan_win ? scan_req : draw_req;

    // ----------------------------------------------------------
    // read return steering
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_from_scan <= 1'b1;             // scan is the usual reader
        end else if (mem_req.req && !mem_req.we) begin
            rd_from_scan <= scan_win;         // remember who read at this edge
        end
    end

    // data lines up with rd_from_scan one cycle after the read
    always_comb begin
        scan_rsp.gnt   = scan_win;            // combinational grant
        draw_rsp.gnt   = draw_win;            // back pressure when low
        scan_rsp.rdata = '0;
        draw_rsp.rdata = '0;
        if (rd_from_scan) begin
            scan_rsp.rdata = mem_rdata;       // pixel back to scan out
        end else begin
            draw_rsp.rdata = mem_rdata;       // read issued by draw side
        end
    end

endmodule

// File: rtl/fb_display_top.sv
`timescale 1ns/100ps

module fb_display_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    enable,     // draw command strobe
    input  fb_mem_pkg::draw_cmd_t   cmd,        // run position, colour, length
    output logic                    busy,       // run in progress
    output logic                    init_done,  // frame cleared after reset
    output disp_timing_pkg::video_t video       // hs, vs, de, rgb
);
    import disp_timing_pkg::*;
    import fb_mem_pkg::*;

    // ----------------------------------------------------------
    // memory port wiring
    // ----------------------------------------------------------
    fb_req_t scan_req;                          // reader side
    fb_rsp_t scan_rsp;
    fb_req_t draw_req;                          // writer side
    fb_rsp_t draw_rsp;
    fb_req_t mem_req;                           // winner onto the RAM
    rgb_t    mem_rdata;

    fb_draw u_fb_draw (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .cmd       (cmd),
        .draw_req  (draw_req),
        .draw_rsp  (draw_rsp),
        .busy      (busy),
        .init_done (init_done)
    );

    fb_scan u_fb_scan (
        .clk       (clk),
        .rst_n     (rst_n),
        .scan_req  (scan_req),
        .scan_rsp  (scan_rsp),
        .video     (video)
    );

    fb_arbiter u_fb_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .scan_req  (scan_req),
        .scan_rsp  (scan_rsp),
        .draw_req  (draw_req),
        .draw_rsp  (draw_rsp),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

    fb_ram u_fb_ram (
        .clk       (clk),
        .req       (mem_req),
        .rdata     (mem_rdata)
    );

endmodule

// File: rtl/fb_draw.sv
`timescale 1ns/100ps

module fb_draw (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,     // command strobe
    input  fb_mem_pkg::draw_cmd_t cmd,        // sampled with enable
    output fb_mem_pkg::fb_req_t   draw_req,   // write only requests
    input  fb_mem_pkg::fb_rsp_t   draw_rsp,
    output logic                  busy,       // run in progress
    output logic                  init_done   // frame cleared
);
    import disp_timing_pkg::*;
    import fb_mem_pkg::*;

    typedef enum logic [1:0] {
        CLEAR,                                // blank the frame after reset
        IDLE,                                 // wait for a command
        RUN                                   // write one pixel run
    } state_t;

    state_t           state;
    logic [FB_AW-1:0] addr_q;                 // next write address
    logic [FB_AW-1:0] cnt_q;                  // pixels left in the run
    rgb_t             pix_q;                  // run colour
    logic             accept;                 // command taken this cycle
    logic             wr_done;                // write completes at this edge
    logic             last_addr;              // at the final frame word

    assign accept    = (state == IDLE) && enable;
    assign wr_done   = draw_req.req & draw_rsp.gnt;
    assign last_addr = (addr_q == FB_AW'(FB_DEPTH - 1));

    assign busy      = (state == RUN);
    assign init_done = (state != CLEAR);      // high from the cycle after the last clear write

    // ----------------------------------------------------------
    // request to the arbiter
    // ----------------------------------------------------------
    always_comb begin
        draw_req.req   = (state == CLEAR) || ((state == RUN) && (cnt_q != '0));
        draw_req.we    = 1'b1;                // this port never reads
        draw_req.addr  = addr_q;              // held until granted
        draw_req.wdata = (state == CLEAR) ? '0 : pix_q;
    end

    // ----------------------------------------------------------
    // control FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= CLEAR;
            addr_q <= '0;                     // clear starts at word 0
        end else begin
            case (state)
                CLEAR: begin
                    if (wr_done) begin
                        addr_q <= addr_q + 1'b1;
                        if (last_addr) begin
                            state <= IDLE;    // whole frame is black
                        end
                    end
                end
                IDLE: begin
                    if (accept) begin
                        state  <= RUN;
                        addr_q <= FB_AW'(cmd.y_pos * H_DISP + cmd.x_pos); // raster start
                    end
                end
                RUN: begin
                    if (cnt_q == '0) begin
                        state <= IDLE;        // empty run, one busy cycle
                    end else if (wr_done) begin
                        addr_q <= addr_q + 1'b1; // wraps into the next line
                        if ((cnt_q == FB_AW'(1)) || last_addr) begin
                            state <= IDLE;    // done or cut at frame end
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // run payload
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            cnt_q <= cmd.len;
            pix_q <= cmd.pixel;
        end else if ((state == RUN) && wr_done) begin
            cnt_q <= cnt_q - 1'b1;            // one pixel written
        end
    end

endmodule

// File: rtl/fb_mem_pkg.sv
package fb_mem_pkg;

    // ----------------------------------------------------------
    // frame memory geometry
    // ----------------------------------------------------------
    localparam int FB_DEPTH = disp_timing_pkg::H_DISP * disp_timing_pkg::V_DISP; // 512 words
    localparam int FB_AW    = $clog2(FB_DEPTH);                   // 9 bit word address

    // one request on the shared memory port
    typedef struct packed {
        logic                  req;                               // access wanted this cycle
        logic                  we;                                // 1 write, 0 read
        logic [FB_AW-1:0]      addr;                              // raster word address
        disp_timing_pkg::rgb_t wdata;                             // write pixel
    } fb_req_t;

    typedef struct packed {
        logic                  gnt;                               // same cycle grant
        disp_timing_pkg::rgb_t rdata;                             // read data, one cycle late
    } fb_rsp_t;

    // ----------------------------------------------------------
    // draw command from the outside
    // ----------------------------------------------------------
    typedef struct packed {
        logic [disp_timing_pkg::X_W-1:0] x_pos;                   // start column
        logic [disp_timing_pkg::Y_W-1:0] y_pos;                   // start row
        disp_timing_pkg::rgb_t           pixel;                   // run colour
        logic [FB_AW-1:0]                len;                     // run length in pixels
    } draw_cmd_t;

endpackage

// File: rtl/fb_ram.sv
`timescale 1ns/100ps

module fb_ram (
    input  logic                  clk,
    input  fb_mem_pkg::fb_req_t   req,      // arbitrated port request
    output disp_timing_pkg::rgb_t rdata     // registered read word
);
    import disp_timing_pkg::*;
    import fb_mem_pkg::*;

    // ----------------------------------------------------------
    // storage
    // ----------------------------------------------------------
    rgb_t mem [FB_DEPTH];                   // one word per visible pixel

    // single port, write or read each cycle
    always_ff @(posedge clk) begin
        if (req.req) begin
            if (req.we) begin
                mem[req.addr] <= req.wdata; // draw side write
            end else begin
                rdata <= mem[req.addr];     // valid the cycle after the request
            end
        end
    end

    // rdata holds its last value on idle and write cycles
    // so the arbiter sees a stable word until the next read

endmodule

// File: rtl/fb_scan.sv
`timescale 1ns/100ps

module fb_scan (
    input  logic                    clk,
    input  logic                    rst_n,
    output fb_mem_pkg::fb_req_t     scan_req,   // read only requests
    input  fb_mem_pkg::fb_rsp_t     scan_rsp,
    output disp_timing_pkg::video_t video       // parallel video out
);
    import disp_timing_pkg::*;
    import fb_mem_pkg::*;

    logic [H_CW-1:0] h_cnt;                     // clock within line
    logic [V_CW-1:0] v_cnt;                     // line within frame
    logic            h_end;                     // last clock of a line
    logic            v_end;                     // last line of a frame
    logic            hs_c;                      // decoded at counter time
    logic            vs_c;
    logic            de_c;
    logic            hs_d;                      // delayed to match read latency
    logic            vs_d;
    logic            de_d;
    logic            fetch_d;                   // a pixel read returns this cycle

    // ----------------------------------------------------------
    // raster counters, free running from reset
    // ----------------------------------------------------------
    assign h_end = (h_cnt == H_CW'(H_TOTAL - 1));
    assign v_end = (v_cnt == V_CW'(V_TOTAL - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_end) begin
            h_cnt <= '0;
            v_cnt <= v_end ? '0 : v_cnt + 1'b1;   // next line or new frame
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // ----------------------------------------------------------
    // window decode, active region first in each count
    // ----------------------------------------------------------
    assign hs_c = (h_cnt >= H_CW'(H_DISP + H_FRONT)) &&
                  (h_cnt <  H_CW'(H_DISP + H_FRONT + H_SYNC));
    assign vs_c = (v_cnt >= V_CW'(V_DISP + V_FRONT)) &&
                  (v_cnt <  V_CW'(V_DISP + V_FRONT + V_SYNC));
    assign de_c = (h_cnt < H_CW'(H_DISP)) && (v_cnt < V_CW'(V_DISP));

    // pixel fetch only inside the active window
    always_comb begin
        scan_req.req   = de_c;
        scan_req.we    = 1'b0;
        scan_req.addr  = FB_AW'(v_cnt * H_DISP + h_cnt); // y*32+x
        scan_req.wdata = '0;
    end

    // ----------------------------------------------------------
    // output alignment
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_d    <= 1'b0;
            vs_d    <= 1'b0;
            de_d    <= 1'b0;
            fetch_d <= 1'b0;
            video   <= '0;
        end else begin
            hs_d    <= hs_c;                    // stage 1 covers the RAM latency
            vs_d    <= vs_c;
            de_d    <= de_c;
            fetch_d <= scan_req.req & scan_rsp.gnt;
            video.hs  <= hs_d;                  // stage 2 registers everything together
            video.vs  <= vs_d;
            video.de  <= de_d;
            video.rgb <= (de_d && fetch_d) ? scan_rsp.rdata : '0; // black in blanking
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build fb_display_tb with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module fb_display_tb \
    -Mdir obj_dir -f fb_display.f \
    || { echo "run_sim: build failed"; exit 1; }

out=$(./obj_dir/Vfb_display_tb)
echo "$out"

echo "$out" | grep -qx "SIMULATION PASSED" \
    && echo "run_sim: pass" \
    && exit 0 \
    || { echo "run_sim: fail"; exit 1; }

// File: tb/fb_display_tb.sv
`timescale 1ns/100ps

module fb_display_tb;
    import disp_timing_pkg::*;
    import fb_mem_pkg::*;

    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;              // 800 clocks
    localparam int MAX_CYCLES   = 40 * FRAME_CYCLES + 4000;       // 40 frames plus margin

    logic      clk;
    logic      rst_n;
    logic      enable;
    draw_cmd_t cmd;
    logic      busy;
    logic      init_done;
    video_t    video;

    rgb_t   model [FB_DEPTH];                                      // expected frame contents
    rgb_t   cap [FB_DEPTH];                                        // pixels seen in this frame
    int     seed;
    int     errors;
    int     passes;
    int     frames_checked;
    int     cyc_cnt;
    int     hs_per;                                                // clocks since hs rise
    int     vs_per;                                                // clocks since vs rise
    int     hs_w;
    int     vs_w;
    int     de_w;
    int     line_cnt;                                              // active lines this frame
    int     pix_idx;                                               // raster index of next pixel
    bit     seen_hs;
    bit     seen_vs;
    bit     frame_clean;                                           // no run touched this frame
    bit     init_seen;
    video_t prev_v;

    fb_display_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .cmd       (cmd),
        .busy      (busy),
        .init_done (init_done),
        .video     (video)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                                     // 4 ns period
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
        end else begin
            passes++;
        end
    endtask

    // raster start with wrap into next lines and cut at the last word
    function automatic void apply_cmd(input draw_cmd_t c);
        int a;
        a = int'(c.y_pos) * H_DISP + int'(c.x_pos);
        for (int i = 0; i < int'(c.len); i++) begin
            if (a + i < FB_DEPTH) begin
                model[a + i] = c.pixel;
            end
        end
    endfunction

    function automatic draw_cmd_t random_cmd(input int idx);
        draw_cmd_t c;
        c.x_pos = X_W'($random(seed));
        c.y_pos = Y_W'($random(seed));
        c.pixel = rgb_t'(24'($random(seed)));
        case (idx % 10)
            3: c.len = '0;                                         // empty run
            7: c.len = FB_AW'($random(seed) & 255);                // long run that wraps lines
            9: begin
                c.y_pos = Y_W'(V_DISP - 1);                        // last line runs off the end
                c.x_pos = X_W'(16 + ($random(seed) & 15));
                c.len   = FB_AW'(32 + ($random(seed) & 63));
            end
            default: c.len = FB_AW'($random(seed) & 63);
        endcase
        return c;
    endfunction

    task automatic send_cmd(input draw_cmd_t c);
        @(posedge clk);
        cmd    <= c;
        enable <= 1'b1;
        @(posedge clk);                                            // sampled at this edge
        enable <= 1'b0;
    endtask

    task automatic wait_idle();
        @(posedge clk);
        while (busy) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_checked_frame();
        int start;
        start = frames_checked;
        while (frames_checked == start) begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(input string name, input int mark);
        $display("test %s finished with %0d errors", name, errors - mark);
    endtask

    // ------------------------------------------------------------
    // video monitor and frame model
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            {hs_per, vs_per, hs_w, vs_w, de_w, line_cnt, pix_idx} = '0;
            {seen_hs, seen_vs, frame_clean, init_seen} = '0;
            prev_v = '0;
        end else begin
            if (busy || enable || !init_done) frame_clean = 1'b0;  // writes may land mid frame
            if (enable && init_done && !busy) apply_cmd(cmd);      // accepted command
            if (init_seen && !init_done) check_eq(32'(init_done), 32'd1, "init_done fell");
            init_seen = init_seen | init_done;
            hs_per++;
            vs_per++;
            if (video.hs) hs_w++;
            if (video.vs) vs_w++;
            if (video.de) de_w++;
            if (video.hs && !prev_v.hs) begin
                if (seen_hs) check_eq(hs_per, H_TOTAL, "cycles between hs rises");
                seen_hs = 1'b1;
                hs_per  = 0;
            end
            if (!video.hs && prev_v.hs) begin
                check_eq(hs_w, H_SYNC, "hs width");
                hs_w = 0;
            end
            if (!video.vs && prev_v.vs) begin
                check_eq(vs_w, V_SYNC * H_TOTAL, "vs width");
                vs_w = 0;
            end
            if (!video.de && prev_v.de) begin
                check_eq(de_w, H_DISP, "de cycles per line");
                de_w = 0;
                line_cnt++;
            end
            if (video.vs && !prev_v.vs) begin
                if (seen_vs) begin
                    check_eq(vs_per, FRAME_CYCLES, "cycles between vs rises");
                    check_eq(line_cnt, V_DISP, "active lines per frame");
                    if (frame_clean) begin
                        check_eq(pix_idx, FB_DEPTH, "de pixels per frame");
                        for (int i = 0; i < FB_DEPTH; i++) begin
                            check_eq(32'(cap[i]), 32'(model[i]), $sformatf("pixel %0d", i));
                        end
                        frames_checked++;
                    end
                end
                seen_vs     = 1'b1;
                vs_per      = 0;
                line_cnt    = 0;
                pix_idx     = 0;
                frame_clean = !(busy || enable || !init_done);
            end
            if (video.de) begin
                if (pix_idx < FB_DEPTH) cap[pix_idx] = video.rgb;  // raster order
                pix_idx++;
            end else begin
                check_eq(32'(video.rgb), 32'd0, "rgb outside de");  // black in blanking
            end
            prev_v = video;
        end
    end

    // run limit
    always @(posedge clk) begin
        cyc_cnt++;
        if (cyc_cnt >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        int        mark;
        int        n;
        draw_cmd_t c;
        seed           = 76;
        rst_n          = 1'b0;
        enable         = 1'b0;
        cmd            = '0;
        errors         = 0;
        passes         = 0;
        frames_checked = 0;
        cyc_cnt        = 0;
        for (int i = 0; i < FB_DEPTH; i++) model[i] = '0;         // cleared frame

        // reset and clear
        mark = errors;
        repeat (8) begin
            @(posedge clk);
            check_eq(32'(video), 32'd0, "video in reset");
            check_eq(32'(busy), 32'd0, "busy in reset");
            check_eq(32'(init_done), 32'd0, "init_done in reset");
        end
        rst_n <= 1'b1;
        c = '{x_pos: X_W'(3), y_pos: Y_W'(2), pixel: rgb_t'(24'hffffff), len: FB_AW'(40)};
        send_cmd(c);                                               // ignored while clearing
        n = 0;
        while (!init_done && n < 3 * FRAME_CYCLES) begin
            @(posedge clk);
            n++;
        end
        check_eq(32'(init_done), 32'd1, "init_done within 3 frames");
        wait_checked_frame();                                      // model is all black here
        report_test("reset_clear", mark);

        // raster timing is checked by the monitor
        mark = errors;
        repeat (2) wait_checked_frame();
        report_test("raster_timing", mark);

        // single run mid line
        mark = errors;
        c = '{x_pos: X_W'(10), y_pos: Y_W'(5), pixel: rgb_t'(24'h3ca55a), len: FB_AW'(12)};
        send_cmd(c);
        wait_idle();
        wait_checked_frame();
        report_test("single_draw", mark);

        // random runs
        mark = errors;
        for (int i = 0; i < 40; i++) begin
            c = random_cmd(i);
            send_cmd(c);
            wait_idle();
            if (i % 10 == 9) wait_checked_frame();
        end
        report_test("random_draws", mark);

        // enable during a run
        mark = errors;
        c = '{x_pos: X_W'(0), y_pos: Y_W'(8), pixel: rgb_t'(24'h00ff80), len: FB_AW'(200)};
        send_cmd(c);
        @(posedge clk);
        check_eq(32'(busy), 32'd1, "busy during long run");
        c = '{x_pos: X_W'(0), y_pos: Y_W'(0), pixel: rgb_t'(24'hffffff), len: FB_AW'(511)};
        send_cmd(c);                                               // dropped while the engine is busy
        wait_idle();
        wait_checked_frame();
        report_test("ignored_enables", mark);

        $display("checks passed %0d, errors %0d, frames checked %0d",
                 passes, errors, frames_checked);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
